// ==== sources.f ====
+incdir+include
hdl/isu_pkg.sv
hdl/isu_ifs.sv
hdl/dispatch.sv
hdl/rob.sv
hdl/busy_table.sv
hdl/int_isq.sv
hdl/pregfile.sv
hdl/isu_top.sv
verif/isu_tb.sv

// ==== Makefile ====
.PHONY: all lint clean

all:
	verilator --binary --timing --assert --top-module isu_tb -f sources.f -Mdir obj_dir -o isu_sim
	./obj_dir/isu_sim > sim.log 2>&1 || true
	cat sim.log
	grep -q "All tests passed!" sim.log

lint:
	verilator --lint-only --timing --assert --top-module isu_tb -f sources.f

clean:
	rm -rf obj_dir sim.log

// ==== include/isu_tb_tasks.svh ====
`ifndef ISU_TB_TASKS_SVH
`define ISU_TB_TASKS_SVH

// one dispatched instruction as the scoreboard tracks it
typedef struct packed {
    robid_t robid;
    xlen_t  pc;
    instr_t instr;
    lreg_t  lrd;
    preg_t  prd;
    preg_t  old_prd;
    logic   need_to_wb;
    logic   src1_is_reg;
    logic   src2_is_reg;
    preg_t  prs1;
    preg_t  prs2;
    xlen_t  imm;
} disp_rec_t;

disp_rec_t issue_q [$];
disp_rec_t commit_q [$];
// issued, still waiting for a writeback
disp_rec_t wb_pend [$];
xlen_t     model_reg [PREG_NUM];
logic      model_busy [PREG_NUM];
logic      wb_seen [2**ROB_IDX_W];
robid_t    next_robid;
preg_t     next_prd;
preg_t     last_prd;
xlen_t     next_pc;

task automatic init_inputs();
    {in_valid, in_pc, in_instr, in_lrd, in_prd, in_old_prd} = '0;
    {in_need_to_wb, in_prs1, in_prs2, in_src1_is_reg, in_src2_is_reg, in_imm} = '0;
    {wb_int_valid, wb_int_robid, wb_int_prd, wb_int_need_to_wb, wb_int_result} = '0;
    {wb_mem_valid, wb_mem_robid, wb_mem_prd, wb_mem_need_to_wb, wb_mem_result} = '0;
    issue_ready = 1'b0;
    for (int i = 0; i < PREG_NUM; i++) begin
        model_reg[i]  = '0;
        model_busy[i] = 1'b0;
    end
    for (int i = 0; i < 2**ROB_IDX_W; i++) begin
        wb_seen[i] = 1'b0;
    end
    next_robid = '0;
    next_prd   = 6'd1;
    last_prd   = '0;
    next_pc    = 64'h8000_0000;
endtask

task automatic model_writeback(input robid_t id, input preg_t p, input logic wb,
                               input xlen_t value);
    wb_seen[id[ROB_IDX_W-1:0]] = 1'b1;
    if (wb) begin
        model_reg[p]  = value;
        model_busy[p] = 1'b0;
    end
endtask

// each call takes a fresh prd, so no preg is reused while in flight
task automatic send_instr(input logic r1, input preg_t p1, input logic r2,
                          input preg_t p2, input logic wb);
    int cycles;
    cycles = 0;
    @(posedge clock);
    in_valid       <= 1'b1;
    in_pc          <= next_pc;
    in_instr       <= $urandom;
    in_lrd         <= 5'($urandom_range(31));
    in_prd         <= next_prd;
    in_old_prd     <= 6'($urandom_range(63));
    in_need_to_wb  <= wb;
    in_prs1        <= p1;
    in_prs2        <= p2;
    in_src1_is_reg <= r1;
    in_src2_is_reg <= r2;
    in_imm         <= {$urandom, $urandom};
    last_prd = next_prd;
    next_prd = (next_prd == 6'd63) ? 6'd1 : next_prd + 1'b1;
    next_pc  = next_pc + 4;
    @(posedge clock);
    while (!in_ready) begin
        if (cycles == TIMEOUT) begin
            fail_now("an instruction was never accepted at dispatch");
        end else begin
            @(posedge clock);
            cycles++;
        end
    end
    in_valid <= 1'b0;
endtask

task automatic write_back(input disp_rec_t r);
    logic  use_mem;
    xlen_t value;
    use_mem = 1'($urandom_range(1));
    value   = {$urandom, $urandom};
    @(posedge clock);
    if (use_mem) begin
        wb_mem_valid      <= 1'b1;
        wb_mem_robid      <= r.robid;
        wb_mem_prd        <= r.prd;
        wb_mem_need_to_wb <= r.need_to_wb;
        wb_mem_result     <= value;
    end else begin
        wb_int_valid      <= 1'b1;
        wb_int_robid      <= r.robid;
        wb_int_prd        <= r.prd;
        wb_int_need_to_wb <= r.need_to_wb;
        wb_int_result     <= value;
    end
    @(posedge clock);
    wb_int_valid <= 1'b0;
    wb_mem_valid <= 1'b0;
endtask

task automatic wait_issue_left(input int n);
    int cycles;
    cycles = 0;
    while (issue_q.size() > n) begin
        if (cycles == TIMEOUT) begin
            fail_now("instructions did not issue in time");
        end else begin
            @(posedge clock);
            cycles++;
        end
    end
endtask

task automatic wait_in_ready();
    int cycles;
    cycles = 0;
    while (!in_ready) begin
        if (cycles == TIMEOUT) begin
            fail_now("in_ready did not rise again");
        end else begin
            @(posedge clock);
            cycles++;
        end
    end
endtask

// writebacks in random order, then wait for every commit
task automatic retire_all();
    int        k;
    int        cycles;
    disp_rec_t r;
    cycles = 0;
    while (wb_pend.size() > 0) begin
        k = $urandom_range(wb_pend.size() - 1);
        r = wb_pend[k];
        wb_pend.delete(k);
        write_back(r);
    end
    while (commit_q.size() > 0) begin
        if (cycles == TIMEOUT) begin
            fail_now("outstanding instructions never committed");
        end else begin
            @(posedge clock);
            cycles++;
        end
    end
endtask

`endif

// ==== verif/isu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module isu_tb import isu_pkg::*; ();
    localparam int ROB_DEPTH = 16;
    localparam int ISQ_DEPTH = 4;
    localparam int TIMEOUT   = 500;

    logic   clock;
    logic   rst_n;
    logic   in_valid;
    logic   in_ready;
    xlen_t  in_pc;
    instr_t in_instr;
    lreg_t  in_lrd;
    preg_t  in_prd;
    preg_t  in_old_prd;
    logic   in_need_to_wb;
    preg_t  in_prs1;
    preg_t  in_prs2;
    logic   in_src1_is_reg;
    logic   in_src2_is_reg;
    xlen_t  in_imm;
    logic   wb_int_valid;
    robid_t wb_int_robid;
    preg_t  wb_int_prd;
    logic   wb_int_need_to_wb;
    xlen_t  wb_int_result;
    logic   wb_mem_valid;
    robid_t wb_mem_robid;
    preg_t  wb_mem_prd;
    logic   wb_mem_need_to_wb;
    xlen_t  wb_mem_result;
    logic   issue_valid;
    logic   issue_ready;
    robid_t issue_robid;
    xlen_t  issue_pc;
    instr_t issue_instr;
    preg_t  issue_prd;
    logic   issue_need_to_wb;
    xlen_t  issue_imm;
    xlen_t  issue_src1;
    xlen_t  issue_src2;
    logic   commit_valid;
    xlen_t  commit_pc;
    instr_t commit_instr;
    lreg_t  commit_lrd;
    preg_t  commit_prd;
    preg_t  commit_old_prd;
    logic   commit_need_to_wb;
    robid_t commit_robid;

    isu_top #(.ROB_DEPTH(ROB_DEPTH), .ISQ_DEPTH(ISQ_DEPTH)) DUT (.*);

    task automatic fail_now(input string what);
        $display("%0t: %s", $time, what);
        $display("Test failures found");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            $display("Fail t=%0t %s got %h expected %h", $time, name, got, exp);
            fail_now("wrong value seen");
        end
    endtask

    `include "isu_tb_tasks.svh"

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // a stalled head keeps its fields
    assert property (@(posedge clock) disable iff (!rst_n)
        (issue_valid && !issue_ready) |=> (issue_valid && $stable(issue_robid) &&
        $stable(issue_pc) && $stable(issue_instr) && $stable(issue_prd) &&
        $stable(issue_need_to_wb) && $stable(issue_imm) &&
        $stable(issue_src1) && $stable(issue_src2)))
    else fail_now("issue fields changed while the head was stalled");

    // all checks sample the settled values from before the edge
    always @(posedge clock) begin : scoreboard
        disp_rec_t r;
        xlen_t     exp1;
        xlen_t     exp2;
        if (rst_n) begin
            if (issue_valid && issue_ready) begin
                if (issue_q.size() == 0) begin
                    fail_now("an instruction issued that was never dispatched");
                end else begin
                    r    = issue_q.pop_front();
                    exp1 = r.src1_is_reg ? model_reg[r.prs1] : '0;
                    exp2 = r.src2_is_reg ? model_reg[r.prs2] : '0;
                    assert (!(r.src1_is_reg && model_busy[r.prs1]) &&
                            !(r.src2_is_reg && model_busy[r.prs2]))
                    else fail_now("an instruction issued before its source was written");
                    check_value("issue_robid", issue_robid, r.robid);
                    check_value("issue_pc", issue_pc, r.pc);
                    check_value("issue_instr", issue_instr, r.instr);
                    check_value("issue_prd", issue_prd, r.prd);
                    check_value("issue_need_to_wb", issue_need_to_wb, r.need_to_wb);
                    check_value("issue_imm", issue_imm, r.imm);
                    check_value("issue_src1", issue_src1, exp1);
                    check_value("issue_src2", issue_src2, exp2);
                    wb_pend.push_back(r);
                end
            end
            if (commit_valid) begin
                if (commit_q.size() == 0) begin
                    fail_now("a commit came with nothing outstanding");
                end else begin
                    r = commit_q.pop_front();
                    assert (wb_seen[r.robid[ROB_IDX_W-1:0]])
                    else fail_now("an instruction committed before its writeback");
                    check_value("commit_robid", commit_robid, r.robid);
                    check_value("commit_pc", commit_pc, r.pc);
                    check_value("commit_instr", commit_instr, r.instr);
                    check_value("commit_lrd", commit_lrd, r.lrd);
                    check_value("commit_prd", commit_prd, r.prd);
                    check_value("commit_old_prd", commit_old_prd, r.old_prd);
                    check_value("commit_need_to_wb", commit_need_to_wb, r.need_to_wb);
                end
            end
            if (wb_int_valid) begin
                model_writeback(wb_int_robid, wb_int_prd, wb_int_need_to_wb, wb_int_result);
            end
            if (wb_mem_valid) begin
                model_writeback(wb_mem_robid, wb_mem_prd, wb_mem_need_to_wb, wb_mem_result);
            end
            // alloc after free, as in the busy table
            if (in_valid && in_ready) begin
                r = '{next_robid, in_pc, in_instr, in_lrd, in_prd, in_old_prd, in_need_to_wb,
                      in_src1_is_reg, in_src2_is_reg, in_prs1, in_prs2, in_imm};
                issue_q.push_back(r);
                commit_q.push_back(r);
                wb_seen[next_robid[ROB_IDX_W-1:0]] = 1'b0;
                if (in_need_to_wb) begin
                    model_busy[in_prd] = 1'b1;
                end
                next_robid = next_robid + 1'b1;
            end
        end
    end

    initial begin
        disp_rec_t r;
        preg_t     dep_prd;
        preg_t     done_prd;
        void'($urandom(5499));
        rst_n     = 1'b0;
        init_inputs();
        repeat (16) @(posedge clock);
        rst_n <= 1'b1;
        @(posedge clock);
        check_value("in_ready", in_ready, 1);
        check_value("issue_valid", issue_valid, 0);
        check_value("commit_valid", commit_valid, 0);

        // independent instructions, immediates only
        issue_ready <= 1'b1;
        repeat (8) send_instr(1'b0, '0, 1'b0, '0, 1'b1);
        wait_issue_left(0);
        retire_all();

        // consumer of an unwritten destination
        done_prd = last_prd;
        send_instr(1'b0, '0, 1'b0, '0, 1'b1);
        dep_prd = last_prd;
        send_instr(1'b1, dep_prd, 1'b1, done_prd, 1'b1);
        wait_issue_left(1);
        repeat (6) @(posedge clock);
        check_value("issue_q size", issue_q.size(), 1);
        r = wb_pend.pop_front();
        write_back(r);
        wait_issue_left(0);
        retire_all();

        // random writeback order, mixed need_to_wb
        repeat (12) send_instr(1'b0, '0, 1'b0, '0, 1'($urandom_range(1)));
        wait_issue_left(0);
        retire_all();

        // issue back-pressure fills the queue
        issue_ready <= 1'b0;
        repeat (ISQ_DEPTH) send_instr(1'b0, '0, 1'b0, '0, 1'b1);
        repeat (3) begin
            @(posedge clock);
            check_value("in_ready", in_ready, 0);
        end
        issue_ready <= 1'b1;
        wait_issue_left(0);
        retire_all();

        // no writebacks until the ROB is full
        repeat (ROB_DEPTH) send_instr(1'b0, '0, 1'b0, '0, 1'b1);
        wait_issue_left(0);
        repeat (3) begin
            @(posedge clock);
            check_value("in_ready", in_ready, 0);
        end
        r = wb_pend.pop_front();
        write_back(r);
        wait_in_ready();
        check_value("commit_q size", commit_q.size(), ROB_DEPTH - 1);
        retire_all();

        repeat (4) @(posedge clock);
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/isu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// ROB_DEPTH must equal 2**ROB_IDX_W from isu_pkg, ISQ_DEPTH a power of two
module isu_top import isu_pkg::*; #(
    parameter int ROB_DEPTH = 16,
    parameter int ISQ_DEPTH = 4
) (
    input  logic   clock,
    input  logic   rst_n,
    input  logic   in_valid,
    output logic   in_ready,
    input  xlen_t  in_pc,
    input  instr_t in_instr,
    input  lreg_t  in_lrd,
    input  preg_t  in_prd,
    input  preg_t  in_old_prd,
    input  logic   in_need_to_wb,
    input  preg_t  in_prs1,
    input  preg_t  in_prs2,
    input  logic   in_src1_is_reg,
    input  logic   in_src2_is_reg,
    input  xlen_t  in_imm,
    input  logic   wb_int_valid,
    input  robid_t wb_int_robid,
    input  preg_t  wb_int_prd,
    input  logic   wb_int_need_to_wb,
    input  xlen_t  wb_int_result,
    input  logic   wb_mem_valid,
    input  robid_t wb_mem_robid,
    input  preg_t  wb_mem_prd,
    input  logic   wb_mem_need_to_wb,
    input  xlen_t  wb_mem_result,
    output logic   issue_valid,
    input  logic   issue_ready,
    output robid_t issue_robid,
    output xlen_t  issue_pc,
    output instr_t issue_instr,
    output preg_t  issue_prd,
    output logic   issue_need_to_wb,
    output xlen_t  issue_imm,
    output xlen_t  issue_src1,
    output xlen_t  issue_src2,
    output logic   commit_valid,
    output xlen_t  commit_pc,
    output instr_t commit_instr,
    output lreg_t  commit_lrd,
    output preg_t  commit_prd,
    output preg_t  commit_old_prd,
    output logic   commit_need_to_wb,
    output robid_t commit_robid
);
    preg_t prf_raddr1;
    preg_t prf_raddr2;
    xlen_t prf_rdata1;
    xlen_t prf_rdata2;

    rob_alloc_if rob_bus ();
    isq_enq_if   isq_bus ();
    bt_if        bt_bus ();
    wb_if        wb_int ();
    wb_if        wb_mem ();

    assign wb_int.valid      = wb_int_valid;
    assign wb_int.robid      = wb_int_robid;
    assign wb_int.prd        = wb_int_prd;
    assign wb_int.need_to_wb = wb_int_need_to_wb;
    assign wb_int.result     = wb_int_result;
    assign wb_mem.valid      = wb_mem_valid;
    assign wb_mem.robid      = wb_mem_robid;
    assign wb_mem.prd        = wb_mem_prd;
    assign wb_mem.need_to_wb = wb_mem_need_to_wb;
    assign wb_mem.result     = wb_mem_result;

    dispatch u_dispatch (
        .clock(clock), .rst_n(rst_n),
        .in_valid(in_valid), .in_ready(in_ready),
        .in_pc(in_pc), .in_instr(in_instr), .in_lrd(in_lrd),
        .in_prd(in_prd), .in_old_prd(in_old_prd), .in_need_to_wb(in_need_to_wb),
        .in_prs1(in_prs1), .in_prs2(in_prs2),
        .in_src1_is_reg(in_src1_is_reg), .in_src2_is_reg(in_src2_is_reg),
        .in_imm(in_imm),
        .rob(rob_bus.initiator), .isq(isq_bus.initiator), .bt(bt_bus.initiator),
        .wb_int(wb_int.monitor), .wb_mem(wb_mem.monitor)
    );

    rob #(.ROB_DEPTH(ROB_DEPTH)) u_rob (
        .clock(clock), .rst_n(rst_n),
        .alloc(rob_bus.target),
        .wb_int(wb_int.monitor), .wb_mem(wb_mem.monitor),
        .commit_valid(commit_valid), .commit_pc(commit_pc),
        .commit_instr(commit_instr), .commit_lrd(commit_lrd),
        .commit_prd(commit_prd), .commit_old_prd(commit_old_prd),
        .commit_need_to_wb(commit_need_to_wb), .commit_robid(commit_robid)
    );

    busy_table u_busy_table (
        .clock(clock), .rst_n(rst_n),
        .bt(bt_bus.target),
        .wb_int(wb_int.monitor), .wb_mem(wb_mem.monitor)
    );

    int_isq #(.ISQ_DEPTH(ISQ_DEPTH)) u_int_isq (
        .clock(clock), .rst_n(rst_n),
        .enq(isq_bus.target),
        .wb_int(wb_int.monitor), .wb_mem(wb_mem.monitor),
        .prf_raddr1(prf_raddr1), .prf_raddr2(prf_raddr2),
        .prf_rdata1(prf_rdata1), .prf_rdata2(prf_rdata2),
        .issue_valid(issue_valid), .issue_ready(issue_ready),
        .issue_robid(issue_robid), .issue_pc(issue_pc), .issue_instr(issue_instr),
        .issue_prd(issue_prd), .issue_need_to_wb(issue_need_to_wb),
        .issue_imm(issue_imm), .issue_src1(issue_src1), .issue_src2(issue_src2)
    );

    pregfile u_pregfile (
        .clock(clock), .rst_n(rst_n),
        .wb_int(wb_int.monitor), .wb_mem(wb_mem.monitor),
        .raddr1(prf_raddr1), .raddr2(prf_raddr2),
        .rdata1(prf_rdata1), .rdata2(prf_rdata2)
    );

endmodule

`default_nettype wire

// ==== hdl/pregfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module pregfile import isu_pkg::*; (
    input  logic  clock,
    input  logic  rst_n,
    wb_if.monitor wb_int,
    wb_if.monitor wb_mem,
    input  preg_t raddr1,
    input  preg_t raddr2,
    output xlen_t rdata1,
    output xlen_t rdata2
);
    xlen_t regs [PREG_NUM];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < PREG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wb_int.valid && wb_int.need_to_wb) begin
                regs[wb_int.prd] <= wb_int.result;
            end
            if (wb_mem.valid && wb_mem.need_to_wb) begin
                regs[wb_mem.prd] <= wb_mem.result;
            end
        end
    end

    // reads see the value before this cycle's write
    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

endmodule

`default_nettype wire

// ==== hdl/int_isq.sv ====
`timescale 1ns/1ps
`default_nettype none

module int_isq import isu_pkg::*; #(
    parameter int ISQ_DEPTH = 4
) (
    input  logic   clock,
    input  logic   rst_n,
    isq_enq_if.target enq,
    wb_if.monitor     wb_int,
    wb_if.monitor     wb_mem,
    output preg_t  prf_raddr1,
    output preg_t  prf_raddr2,
    input  xlen_t  prf_rdata1,
    input  xlen_t  prf_rdata2,
    output logic   issue_valid,
    input  logic   issue_ready,
    output robid_t issue_robid,
    output xlen_t  issue_pc,
    output instr_t issue_instr,
    output preg_t  issue_prd,
    output logic   issue_need_to_wb,
    output xlen_t  issue_imm,
    output xlen_t  issue_src1,
    output xlen_t  issue_src2
);
    localparam int PW = $clog2(ISQ_DEPTH);

    logic [PW:0]          head;
    logic [PW:0]          tail;
    logic [PW-1:0]        head_idx;
    logic [PW-1:0]        tail_idx;
    logic                 empty;
    logic                 full;
    logic                 do_enq;
    logic [ISQ_DEPTH-1:0] rdy1;
    logic [ISQ_DEPTH-1:0] rdy2;

    robid_t q_robid       [ISQ_DEPTH];
    xlen_t  q_pc          [ISQ_DEPTH];
    instr_t q_instr       [ISQ_DEPTH];
    preg_t  q_prd         [ISQ_DEPTH];
    logic   q_need_to_wb  [ISQ_DEPTH];
    preg_t  q_prs1        [ISQ_DEPTH];
    preg_t  q_prs2        [ISQ_DEPTH];
    logic   q_src1_is_reg [ISQ_DEPTH];
    logic   q_src2_is_reg [ISQ_DEPTH];
    xlen_t  q_imm         [ISQ_DEPTH];

    assign head_idx    = head[PW-1:0];
    assign tail_idx    = tail[PW-1:0];
    assign empty       = (head == tail);
    assign full        = (head_idx == tail_idx) && (head[PW] != tail[PW]);
    assign enq.can_enq = !full;
    assign do_enq      = enq.enq_valid && !full;

    always_ff @(posedge clock) begin
        if (do_enq) begin
            q_robid[tail_idx]       <= enq.robid;
            q_pc[tail_idx]          <= enq.pc;
            q_instr[tail_idx]       <= enq.instr;
            q_prd[tail_idx]         <= enq.prd;
            q_need_to_wb[tail_idx]  <= enq.need_to_wb;
            q_prs1[tail_idx]        <= enq.prs1;
            q_prs2[tail_idx]        <= enq.prs2;
            q_src1_is_reg[tail_idx] <= enq.src1_is_reg;
            q_src2_is_reg[tail_idx] <= enq.src2_is_reg;
            q_imm[tail_idx]         <= enq.imm;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            head <= '0;
            tail <= '0;
            rdy1 <= '0;
            rdy2 <= '0;
        end else begin
            // wakeup of any waiting source
            for (int i = 0; i < ISQ_DEPTH; i++) begin
                if (wb_hit(wb_int.valid, wb_int.need_to_wb, wb_int.prd, q_prs1[i]) ||
                    wb_hit(wb_mem.valid, wb_mem.need_to_wb, wb_mem.prd, q_prs1[i])) begin
                    rdy1[i] <= 1'b1;
                end
                if (wb_hit(wb_int.valid, wb_int.need_to_wb, wb_int.prd, q_prs2[i]) ||
                    wb_hit(wb_mem.valid, wb_mem.need_to_wb, wb_mem.prd, q_prs2[i])) begin
                    rdy2[i] <= 1'b1;
                end
            end
            // new entry already carries the same-cycle bypass from dispatch
            if (do_enq) begin
                rdy1[tail_idx] <= enq.src1_ready;
                rdy2[tail_idx] <= enq.src2_ready;
                tail           <= tail + 1'b1;
            end
            if (issue_valid && issue_ready) begin
                head <= head + 1'b1;
            end
        end
    end

    // in order, only the head may issue
    assign issue_valid      = !empty && rdy1[head_idx] && rdy2[head_idx];
    assign issue_robid      = q_robid[head_idx];
    assign issue_pc         = q_pc[head_idx];
    assign issue_instr      = q_instr[head_idx];
    assign issue_prd        = q_prd[head_idx];
    assign issue_need_to_wb = q_need_to_wb[head_idx];
    assign issue_imm        = q_imm[head_idx];

    assign prf_raddr1 = q_prs1[head_idx];
    assign prf_raddr2 = q_prs2[head_idx];
    assign issue_src1 = q_src1_is_reg[head_idx] ? prf_rdata1 : '0;
    assign issue_src2 = q_src2_is_reg[head_idx] ? prf_rdata2 : '0;

endmodule

`default_nettype wire

// ==== hdl/busy_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module busy_table import isu_pkg::*; (
    input  logic clock,
    input  logic rst_n,
    bt_if.target  bt,
    wb_if.monitor wb_int,
    wb_if.monitor wb_mem
);
    logic [PREG_NUM-1:0] busy;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            busy <= '0;
        end else begin
            if (wb_int.valid && wb_int.need_to_wb) begin
                busy[wb_int.prd] <= 1'b0;
            end
            if (wb_mem.valid && wb_mem.need_to_wb) begin
                busy[wb_mem.prd] <= 1'b0;
            end
            // alloc comes last so it wins over a free
            if (bt.alloc_en) begin
                busy[bt.alloc_prd] <= 1'b1;
            end
        end
    end

    assign bt.rs1_busy = busy[bt.rs1];
    assign bt.rs2_busy = busy[bt.rs2];

endmodule

`default_nettype wire

// ==== hdl/rob.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob import isu_pkg::*; #(
    parameter int ROB_DEPTH = 16
) (
    input  logic   clock,
    input  logic   rst_n,
    rob_alloc_if.target alloc,
    wb_if.monitor       wb_int,
    wb_if.monitor       wb_mem,
    output logic   commit_valid,
    output xlen_t  commit_pc,
    output instr_t commit_instr,
    output lreg_t  commit_lrd,
    output preg_t  commit_prd,
    output preg_t  commit_old_prd,
    output logic   commit_need_to_wb,
    output robid_t commit_robid
);
    robid_t                 head;
    robid_t                 tail;
    logic [ROB_IDX_W-1:0]   head_idx;
    logic [ROB_IDX_W-1:0]   tail_idx;
    logic                   empty;
    logic                   full;
    logic                   do_alloc;
    logic [ROB_DEPTH-1:0]   complete;

    xlen_t  ent_pc         [ROB_DEPTH];
    instr_t ent_instr      [ROB_DEPTH];
    lreg_t  ent_lrd        [ROB_DEPTH];
    preg_t  ent_prd        [ROB_DEPTH];
    preg_t  ent_old_prd    [ROB_DEPTH];
    logic   ent_need_to_wb [ROB_DEPTH];

    assign head_idx = head[ROB_IDX_W-1:0];
    assign tail_idx = tail[ROB_IDX_W-1:0];
    // same slot, flags tell full from empty
    assign empty    = (head == tail);
    assign full     = (head_idx == tail_idx) && (head[ROB_IDX_W] != tail[ROB_IDX_W]);

    assign alloc.can_alloc = !full;
    assign alloc.robid     = tail;
    assign do_alloc        = alloc.alloc_valid && !full;

    always_ff @(posedge clock) begin
        if (do_alloc) begin
            ent_pc[tail_idx]         <= alloc.pc;
            ent_instr[tail_idx]      <= alloc.instr;
            ent_lrd[tail_idx]        <= alloc.lrd;
            ent_prd[tail_idx]        <= alloc.prd;
            ent_old_prd[tail_idx]    <= alloc.old_prd;
            ent_need_to_wb[tail_idx] <= alloc.need_to_wb;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            head     <= '0;
            tail     <= '0;
            complete <= '0;
        end else begin
            if (do_alloc) begin
                tail               <= tail + 1'b1;
                complete[tail_idx] <= 1'b0;
            end
            // completion from either writeback port
            if (wb_int.valid) begin
                complete[wb_int.robid[ROB_IDX_W-1:0]] <= 1'b1;
            end
            if (wb_mem.valid) begin
                complete[wb_mem.robid[ROB_IDX_W-1:0]] <= 1'b1;
            end
            if (commit_valid) begin
                head <= head + 1'b1;
            end
        end
    end

    // retire the head once it has written back
    assign commit_valid      = !empty && complete[head_idx];
    assign commit_pc         = ent_pc[head_idx];
    assign commit_instr      = ent_instr[head_idx];
    assign commit_lrd        = ent_lrd[head_idx];
    assign commit_prd        = ent_prd[head_idx];
    assign commit_old_prd    = ent_old_prd[head_idx];
    assign commit_need_to_wb = ent_need_to_wb[head_idx];
    assign commit_robid      = head;

endmodule

`default_nettype wire

// ==== hdl/dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module dispatch import isu_pkg::*; (
    input  logic   clock,
    input  logic   rst_n,
    input  logic   in_valid,
    output logic   in_ready,
    input  xlen_t  in_pc,
    input  instr_t in_instr,
    input  lreg_t  in_lrd,
    input  preg_t  in_prd,
    input  preg_t  in_old_prd,
    input  logic   in_need_to_wb,
    input  preg_t  in_prs1,
    input  preg_t  in_prs2,
    input  logic   in_src1_is_reg,
    input  logic   in_src2_is_reg,
    input  xlen_t  in_imm,
    rob_alloc_if.initiator rob,
    isq_enq_if.initiator   isq,
    bt_if.initiator        bt,
    wb_if.monitor          wb_int,
    wb_if.monitor          wb_mem
);
    logic fire;
    logic src1_bypass;
    logic src2_bypass;

    // both structures need a free slot
    assign in_ready = rob.can_alloc && isq.can_enq;
    assign fire     = in_valid && in_ready;

    assign rob.alloc_valid = fire;
    assign rob.pc          = in_pc;
    assign rob.instr       = in_instr;
    assign rob.lrd         = in_lrd;
    assign rob.prd         = in_prd;
    assign rob.old_prd     = in_old_prd;
    assign rob.need_to_wb  = in_need_to_wb;

    // source lookup, plus a writeback landing this very cycle
    assign bt.rs1 = in_prs1;
    assign bt.rs2 = in_prs2;

    assign src1_bypass = wb_hit(wb_int.valid, wb_int.need_to_wb, wb_int.prd, in_prs1) ||
                         wb_hit(wb_mem.valid, wb_mem.need_to_wb, wb_mem.prd, in_prs1);
    assign src2_bypass = wb_hit(wb_int.valid, wb_int.need_to_wb, wb_int.prd, in_prs2) ||
                         wb_hit(wb_mem.valid, wb_mem.need_to_wb, wb_mem.prd, in_prs2);

    assign isq.enq_valid   = fire;
    assign isq.robid       = rob.robid;
    assign isq.pc          = in_pc;
    assign isq.instr       = in_instr;
    assign isq.prd         = in_prd;
    assign isq.need_to_wb  = in_need_to_wb;
    assign isq.prs1        = in_prs1;
    assign isq.prs2        = in_prs2;
    assign isq.src1_is_reg = in_src1_is_reg;
    assign isq.src2_is_reg = in_src2_is_reg;
    assign isq.imm         = in_imm;
    assign isq.src1_ready  = !in_src1_is_reg || !bt.rs1_busy || src1_bypass;
    assign isq.src2_ready  = !in_src2_is_reg || !bt.rs2_busy || src2_bypass;

    // destination becomes busy until its writeback
    assign bt.alloc_en  = fire && in_need_to_wb;
    assign bt.alloc_prd = in_prd;

endmodule

`default_nettype wire

// ==== hdl/isu_ifs.sv ====
`timescale 1ns/1ps
`default_nettype none

// dispatch to rob allocation
interface rob_alloc_if import isu_pkg::*; ();
    logic   alloc_valid;
    xlen_t  pc;
    instr_t instr;
    lreg_t  lrd;
    preg_t  prd;
    preg_t  old_prd;
    logic   need_to_wb;
    logic   can_alloc;
    robid_t robid;

    modport initiator (
        output alloc_valid, pc, instr, lrd, prd, old_prd, need_to_wb,
        input  can_alloc, robid
    );
    modport target (
        input  alloc_valid, pc, instr, lrd, prd, old_prd, need_to_wb,
        output can_alloc, robid
    );
endinterface

// dispatch to issue queue enqueue
interface isq_enq_if import isu_pkg::*; ();
    logic   enq_valid;
    robid_t robid;
    xlen_t  pc;
    instr_t instr;
    preg_t  prd;
    logic   need_to_wb;
    preg_t  prs1;
    preg_t  prs2;
    logic   src1_is_reg;
    logic   src2_is_reg;
    xlen_t  imm;
    logic   src1_ready;
    logic   src2_ready;
    logic   can_enq;

    modport initiator (
        output enq_valid, robid, pc, instr, prd, need_to_wb, prs1, prs2,
        output src1_is_reg, src2_is_reg, imm, src1_ready, src2_ready,
        input  can_enq
    );
    modport target (
        input  enq_valid, robid, pc, instr, prd, need_to_wb, prs1, prs2,
        input  src1_is_reg, src2_is_reg, imm, src1_ready, src2_ready,
        output can_enq
    );
endinterface

// busy table lookup and allocation
interface bt_if import isu_pkg::*; ();
    preg_t rs1;
    preg_t rs2;
    logic  rs1_busy;
    logic  rs2_busy;
    logic  alloc_en;
    preg_t alloc_prd;

    modport initiator (output rs1, rs2, alloc_en, alloc_prd, input rs1_busy, rs2_busy);
    modport target (input rs1, rs2, alloc_en, alloc_prd, output rs1_busy, rs2_busy);
endinterface

// one writeback port, single cycle strobe
interface wb_if import isu_pkg::*; ();
    logic   valid;
    robid_t robid;
    preg_t  prd;
    logic   need_to_wb;
    xlen_t  result;

    modport monitor (input valid, robid, prd, need_to_wb, result);
endinterface

`default_nettype wire

// ==== hdl/isu_pkg.sv ====
`default_nettype none

package isu_pkg;

    parameter int XLEN      = 64;
    parameter int PREG_NUM  = 64;
    parameter int PREG_W    = $clog2(PREG_NUM);
    parameter int ROB_IDX_W = 4;

    typedef logic [PREG_W-1:0]  preg_t;
    typedef logic [4:0]         lreg_t;
    typedef logic [XLEN-1:0]    xlen_t;
    typedef logic [31:0]        instr_t;
    // top bit is the wrap flag
    typedef logic [ROB_IDX_W:0] robid_t;

    // true when a writeback port produces a value for preg p this cycle
    function automatic logic wb_hit(
        input logic  valid,
        input logic  need_to_wb,
        input preg_t wb_prd,
        input preg_t p
    );
        return valid && need_to_wb && (wb_prd == p);
    endfunction

endpackage

`default_nettype wire
